// ==== dep_checker.sv ====
`timescale 1ns/1ps

module dep_checker import dep_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic dec_valid,
	input logic dep_ready,
	input logic exp_split,
	input logic [57:0] even_in,
	input logic [57:0] odd_in,
	input logic even_valid,
	input logic odd_valid,
	input logic [57:0] even_out,
	input logic [57:0] odd_out,
	output int errors,
	output int tests_done,
	output logic busy
);

	localparam int max_pairs = 64;

	int cyc = 0;
	int ready_at [128];
	logic [57:0] pair_slot [max_pairs][2];
	logic pair_split [max_pairs];
	int n_acc;
	int cur;
	int acc_edge;
	logic acc_new;
	int flush_edge;
	int err_base;
	logic pend [2];
	int at [2];
	int seen [2];
	string side [2] = '{"even", "odd"};
	int nop [2] = '{1, 513};

	initial errors = 0;
	initial tests_done = 0;

	function automatic int max2(int a, int b);
		return (a > b) ? a : b;
	endfunction

	// Cycles a consumer waits behind this producer
	function automatic int lat_of(logic [57:0] s);
		logic [10:0] op;
		op = s[57:47];
		case (s[46:44])
			3'd1: return 2;
			3'd2, 3'd5, 3'd6, 3'd7: return 4;
			3'd3: return 6;
			3'd4: return (op inside {11'd12, 11'd964, 11'd965, 11'd966, 11'd967}) ? 7 : 6;
			default: return 1;
		endcase
	endfunction

	function automatic int src_ready(logic [57:0] s);
		return max2(ready_at[s[43:37]], max2(ready_at[s[36:30]], ready_at[s[29:23]]));
	endfunction

	task automatic compare_field(string name, int exp, int act);
		if (exp != act)
		begin
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_slot(string s, logic [57:0] exp, logic [57:0] act);
		compare_field({s, "_opcode"}, exp[57:47], act[57:47]);
		compare_field({s, "_unit"}, exp[46:44], act[46:44]);
		compare_field({s, "_ra"}, exp[43:37], act[43:37]);
		compare_field({s, "_rb"}, exp[36:30], act[36:30]);
		compare_field({s, "_rc"}, exp[29:23], act[29:23]);
		compare_field({s, "_rt"}, exp[22:16], act[22:16]);
		compare_field({s, "_imm"}, exp[15:0], act[15:0]);
	endtask

	task automatic close_pair(string how);
		$display("pair %0d %s: even at cycle %0d, odd at cycle %0d, %s", cur, how,
			seen[0], seen[1], (errors == err_base) ? "ok" : "with errors");
		tests_done++;
	endtask

	always @(posedge clk)
		cyc <= cyc + 1;

	assign busy = pend[0] || pend[1] || acc_new;

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		logic vld [2];
		logic [57:0] outs [2];
		int e;
		int o;
		logic exp_ready;
		vld[0] = even_valid;
		vld[1] = odd_valid;
		outs[0] = even_out;
		outs[1] = odd_out;
		if (!rst_n)
		begin
			pend = '{1'b0, 1'b0};
			acc_new = 1'b0;
			flush_edge = -1;
			n_acc = 0;
			cur = -1;
			foreach (ready_at[r])
				ready_at[r] = 0;
		end
		else
		begin
			if (flush_edge == cyc && (pend[0] || pend[1]))
			begin
				pend = '{1'b0, 1'b0};
				close_pair("flushed");
			end
			for (int s = 0; s < 2; s++)
			begin
				if (pend[s] && at[s] == cyc)
				begin
					if (!vld[s])
					begin
						$display("At %0t the %s slot of pair %0d did not issue at cycle %0d",
							$time, side[s], cur, cyc);
						errors++;
					end
					else
					begin
						compare_slot(side[s], pair_slot[cur][s], outs[s]);
						ready_at[outs[s][22:16]] = max2(ready_at[outs[s][22:16]],
							cyc + lat_of(outs[s]));
						seen[s] = cyc;
					end
					pend[s] = 1'b0;
					if (!pend[0] && !pend[1])
					begin
						// Slot order seen on the outputs against the table
						if (seen[0] >= 0 && seen[1] >= 0 &&
							((seen[0] != seen[1]) != pair_split[cur]))
						begin
							$display("Pair %0d issued its slots in an order the table does not expect",
								cur);
							errors++;
						end
						close_pair("issued");
					end
				end
				else
				begin
					if (vld[s])
					begin
						$display("At %0t the %s slot issued when no issue was due", $time, side[s]);
						errors++;
					end
					compare_field({side[s], "_opcode"}, nop[s], outs[s][57:47]);
				end
			end

			// Predict the issue cycles of a pair accepted at this edge
			if (acc_new && acc_edge == cyc)
			begin
				cur = n_acc - 1;
				err_base = errors;
				e = max2(cyc + 1, src_ready(pair_slot[cur][0]));
				o = max2(cyc + 1, src_ready(pair_slot[cur][1]));
				if (pair_slot[cur][1][43:37] == pair_slot[cur][0][22:16] ||
					pair_slot[cur][1][36:30] == pair_slot[cur][0][22:16] ||
					pair_slot[cur][1][29:23] == pair_slot[cur][0][22:16])
				begin
					at[0] = e;
					at[1] = max2(o, e + lat_of(pair_slot[cur][0]));
				end
				else
				begin
					at[0] = max2(e, o);
					at[1] = max2(e, o);
				end
				seen = '{-1, -1};
				pend = '{1'b1, 1'b1};
				acc_new = 1'b0;
			end

			exp_ready = !flush && (!pend[0] || at[0] == cyc + 1) && (!pend[1] || at[1] == cyc + 1);
			if (dep_ready !== exp_ready)
			begin
				$display("FAILED at %0t: dep_ready expected %0d, got %0d", $time, exp_ready,
					dep_ready);
				errors++;
			end

			if (dec_valid && dep_ready && n_acc < max_pairs)
			begin
				pair_slot[n_acc][0] = even_in;
				pair_slot[n_acc][1] = odd_in;
				pair_split[n_acc] = exp_split;
				n_acc++;
				acc_edge = cyc + 1;
				acc_new = 1'b1;
			end
			if (flush)
				flush_edge = cyc + 1;
		end
	end

endmodule

// ==== dep_pkg.sv ====
package dep_pkg;

	localparam int reg_addr_w = 7;
	localparam int opcode_w = 11;
	localparam int unit_w = 3;
	localparam int imm_w = 16;
	localparam int lat_w = 4;

	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [opcode_w-1:0] opcode_t;
	typedef logic [unit_w-1:0] unit_t;
	typedef logic signed [imm_w-1:0] imm_t;
	typedef logic [lat_w-1:0] lat_t;

	// Longest result latency, so also the history length
	localparam int hist_depth = 7;

	// Even pipe units
	localparam unit_t unit_simple = 3'd1;
	localparam unit_t unit_byte = 3'd2;
	localparam unit_t unit_float = 3'd4;
	localparam unit_t unit_word = 3'd5;

	// Odd pipe units
	localparam unit_t unit_load = 3'd3;
	localparam unit_t unit_perm = 3'd6;
	localparam unit_t unit_branch = 3'd7;

	// Opcodes shown by a slot that does not issue
	localparam opcode_t nop_even = 11'd1;
	localparam opcode_t nop_odd = 11'd513;

	localparam int float_set_n = 5;
	localparam opcode_t float_single_ops [float_set_n] =
		'{11'd707, 11'd716, 11'd718, 11'd860, 11'd963};
	localparam opcode_t float_long_ops [float_set_n] =
		'{11'd12, 11'd964, 11'd965, 11'd966, 11'd967};

	function automatic logic op_in_set(opcode_t op, opcode_t set [float_set_n]);
		logic hit;
		hit = 1'b0;
		foreach (set[i])
			if (set[i] == op)
				hit = 1'b1;
		return hit;
	endfunction

	// Cycles from issue until a consumer may issue
	function automatic lat_t result_latency(unit_t unit, opcode_t opcode);
		lat_t lat;
		case (unit)
			unit_simple: lat = 4'd2;
			unit_byte, unit_word: lat = 4'd4;
			// Unlisted float opcodes run down the single path
			unit_float: lat = (op_in_set(opcode, float_single_ops) ||
				!op_in_set(opcode, float_long_ops)) ? 4'd6 : 4'd7;
			unit_perm, unit_branch: lat = 4'd4;
			unit_load: lat = 4'd6;
			default: lat = 4'd1;
		endcase
		return lat;
	endfunction

endpackage

// ==== dep_slot_if.sv ====
`timescale 1ns/1ps

// One instruction slot as it moves between the blocks of the stage
interface dep_slot_if import dep_pkg::*; ();

	opcode_t opcode;
	unit_t unit;
	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rc;
	reg_addr_t rt;
	imm_t imm;

	modport src
	(
		output opcode, unit, ra, rb, rc, rt, imm
	);

	modport dst
	(
		input opcode, unit, ra, rb, rc, rt, imm
	);

endinterface

// ==== dep_stage.sv ====
`timescale 1ns/1ps

module dep_stage import dep_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic dec_valid,
	output logic dep_ready,
	input opcode_t even_in_opcode,
	input unit_t even_in_unit,
	input reg_addr_t even_in_ra,
	input reg_addr_t even_in_rb,
	input reg_addr_t even_in_rc,
	input reg_addr_t even_in_rt,
	input imm_t even_in_imm,
	input opcode_t odd_in_opcode,
	input unit_t odd_in_unit,
	input reg_addr_t odd_in_ra,
	input reg_addr_t odd_in_rb,
	input reg_addr_t odd_in_rc,
	input reg_addr_t odd_in_rt,
	input imm_t odd_in_imm,
	output logic even_valid,
	output opcode_t even_opcode,
	output unit_t even_unit,
	output reg_addr_t even_ra,
	output reg_addr_t even_rb,
	output reg_addr_t even_rc,
	output reg_addr_t even_rt,
	output imm_t even_imm,
	output logic odd_valid,
	output opcode_t odd_opcode,
	output unit_t odd_unit,
	output reg_addr_t odd_ra,
	output reg_addr_t odd_rb,
	output reg_addr_t odd_rc,
	output reg_addr_t odd_rt,
	output imm_t odd_imm
);

	dep_slot_if in_even();
	dep_slot_if in_odd();
	dep_slot_if pend_even();
	dep_slot_if pend_odd();
	dep_slot_if out_even();
	dep_slot_if out_odd();

	reg_addr_t even_hist_rt [hist_depth];
	reg_addr_t odd_hist_rt [hist_depth];
	lat_t even_hist_left [hist_depth];
	lat_t odd_hist_left [hist_depth];
	logic even_blocked;
	logic odd_blocked;

	// Decoder pair into the slot bundles
	assign in_even.opcode = even_in_opcode;
	assign in_even.unit = even_in_unit;
	assign in_even.ra = even_in_ra;
	assign in_even.rb = even_in_rb;
	assign in_even.rc = even_in_rc;
	assign in_even.rt = even_in_rt;
	assign in_even.imm = even_in_imm;
	assign in_odd.opcode = odd_in_opcode;
	assign in_odd.unit = odd_in_unit;
	assign in_odd.ra = odd_in_ra;
	assign in_odd.rb = odd_in_rb;
	assign in_odd.rc = odd_in_rc;
	assign in_odd.rt = odd_in_rt;
	assign in_odd.imm = odd_in_imm;

	// Issued slots out to the pipes
	assign even_opcode = out_even.opcode;
	assign even_unit = out_even.unit;
	assign even_ra = out_even.ra;
	assign even_rb = out_even.rb;
	assign even_rc = out_even.rc;
	assign even_rt = out_even.rt;
	assign even_imm = out_even.imm;
	assign odd_opcode = out_odd.opcode;
	assign odd_unit = out_odd.unit;
	assign odd_ra = out_odd.ra;
	assign odd_rb = out_odd.rb;
	assign odd_rc = out_odd.rc;
	assign odd_rt = out_odd.rt;
	assign odd_imm = out_odd.imm;

	issue_control i_ctrl
	(
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.dec_valid(dec_valid),
		.dep_ready(dep_ready),
		.in_even(in_even),
		.in_odd(in_odd),
		.pend_even(pend_even),
		.pend_odd(pend_odd),
		.out_even(out_even),
		.out_odd(out_odd),
		.even_valid(even_valid),
		.odd_valid(odd_valid),
		.even_blocked(even_blocked),
		.odd_blocked(odd_blocked)
	);

	issue_history i_hist
	(
		.clk(clk),
		.rst_n(rst_n),
		.even_valid(even_valid),
		.odd_valid(odd_valid),
		.out_even(out_even),
		.out_odd(out_odd),
		.even_hist_rt(even_hist_rt),
		.odd_hist_rt(odd_hist_rt),
		.even_hist_left(even_hist_left),
		.odd_hist_left(odd_hist_left)
	);

	operand_hazard i_haz_even
	(
		.pend(pend_even),
		.pend_valid(i_ctrl.even_pend),
		.out_even(out_even),
		.out_odd(out_odd),
		.even_valid(even_valid),
		.odd_valid(odd_valid),
		.even_hist_rt(even_hist_rt),
		.odd_hist_rt(odd_hist_rt),
		.even_hist_left(even_hist_left),
		.odd_hist_left(odd_hist_left),
		.blocked(even_blocked)
	);

	operand_hazard i_haz_odd
	(
		.pend(pend_odd),
		.pend_valid(i_ctrl.odd_pend),
		.out_even(out_even),
		.out_odd(out_odd),
		.even_valid(even_valid),
		.odd_valid(odd_valid),
		.even_hist_rt(even_hist_rt),
		.odd_hist_rt(odd_hist_rt),
		.even_hist_left(even_hist_left),
		.odd_hist_left(odd_hist_left),
		.blocked(odd_blocked)
	);

endmodule

// ==== files.f ====
dep_pkg.sv
dep_slot_if.sv
issue_history.sv
operand_hazard.sv
issue_control.sv
dep_stage.sv
dep_checker.sv
tb_dep_stage.sv

// ==== issue_control.sv ====
`timescale 1ns/1ps

module issue_control import dep_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic dec_valid,
	output logic dep_ready,
	dep_slot_if.dst in_even,
	dep_slot_if.dst in_odd,
	dep_slot_if.src pend_even,
	dep_slot_if.src pend_odd,
	dep_slot_if.src out_even,
	dep_slot_if.src out_odd,
	output logic even_valid,
	output logic odd_valid,
	input logic even_blocked,
	input logic odd_blocked
);

	logic even_pend;
	logic odd_pend;
	logic split;
	logic issue_even;
	logic issue_odd;
	logic pair_done;
	logic accept;

	// Odd slot reads the result of its own even slot
	assign split = even_pend && odd_pend &&
		((pend_odd.ra == pend_even.rt) || (pend_odd.rb == pend_even.rt) ||
		(pend_odd.rc == pend_even.rt));

	// Lockstep unless split, then even goes first on its own
	assign issue_even = even_pend && !even_blocked && (!odd_pend || split || !odd_blocked);
	assign issue_odd = odd_pend && !odd_blocked &&
		(!even_pend || (!split && !even_blocked));

	assign pair_done = (!even_pend || issue_even) && (!odd_pend || issue_odd);
	assign dep_ready = !flush && pair_done;
	assign accept = dec_valid && dep_ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			even_pend <= 1'b0;
			odd_pend <= 1'b0;
		end
		else if (accept)
		begin
			even_pend <= 1'b1;
			odd_pend <= 1'b1;
		end
		else
		begin
			even_pend <= even_pend && !issue_even;
			odd_pend <= odd_pend && !issue_odd;
		end
	end

	// Pending pair payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			pend_even.opcode <= in_even.opcode;
			pend_even.unit <= in_even.unit;
			pend_even.ra <= in_even.ra;
			pend_even.rb <= in_even.rb;
			pend_even.rc <= in_even.rc;
			pend_even.rt <= in_even.rt;
			pend_even.imm <= in_even.imm;
			pend_odd.opcode <= in_odd.opcode;
			pend_odd.unit <= in_odd.unit;
			pend_odd.ra <= in_odd.ra;
			pend_odd.rb <= in_odd.rb;
			pend_odd.rc <= in_odd.rc;
			pend_odd.rt <= in_odd.rt;
			pend_odd.imm <= in_odd.imm;
		end
	end

	// Valids and opcodes, a slot not issuing shows its nop
	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			even_valid <= 1'b0;
			odd_valid <= 1'b0;
			out_even.opcode <= nop_even;
			out_odd.opcode <= nop_odd;
		end
		else
		begin
			even_valid <= issue_even;
			odd_valid <= issue_odd;
			out_even.opcode <= issue_even ? pend_even.opcode : nop_even;
			out_odd.opcode <= issue_odd ? pend_odd.opcode : nop_odd;
		end
	end

	// Remaining output fields only change on issue
	always_ff @(posedge clk)
	begin
		if (issue_even)
		begin
			out_even.unit <= pend_even.unit;
			out_even.ra <= pend_even.ra;
			out_even.rb <= pend_even.rb;
			out_even.rc <= pend_even.rc;
			out_even.rt <= pend_even.rt;
			out_even.imm <= pend_even.imm;
		end
		if (issue_odd)
		begin
			out_odd.unit <= pend_odd.unit;
			out_odd.ra <= pend_odd.ra;
			out_odd.rb <= pend_odd.rb;
			out_odd.rc <= pend_odd.rc;
			out_odd.rt <= pend_odd.rt;
			out_odd.imm <= pend_odd.imm;
		end
	end

	// Odd issues with its even slot or after the even slot has left
	a_odd_after_even: assert property (@(posedge clk) disable iff (!rst_n)
		odd_valid |-> (even_valid || $past(!even_pend)));

	// Once flush drops, nothing is left pending
	a_ready_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> (dep_ready || flush));

endmodule

// ==== issue_history.sv ====
`timescale 1ns/1ps

module issue_history import dep_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic even_valid,
	input logic odd_valid,
	dep_slot_if.dst out_even,
	dep_slot_if.dst out_odd,
	output reg_addr_t even_hist_rt [hist_depth],
	output reg_addr_t odd_hist_rt [hist_depth],
	output lat_t even_hist_left [hist_depth],
	output lat_t odd_hist_left [hist_depth]
);

	lat_t even_lat;
	lat_t odd_lat;

	assign even_lat = result_latency(out_even.unit, out_even.opcode);
	assign odd_lat = result_latency(out_odd.unit, out_odd.opcode);

	// One cycle of ageing, floored at zero
	function automatic lat_t age_one(lat_t left);
		return (left > 4'd0) ? left - 4'd1 : 4'd0;
	endfunction

	// Destination registers just follow the shift
	always_ff @(posedge clk)
	begin
		even_hist_rt[0] <= out_even.rt;
		odd_hist_rt[0] <= out_odd.rt;
		for (int k = 1; k < hist_depth; k++)
		begin
			even_hist_rt[k] <= even_hist_rt[k-1];
			odd_hist_rt[k] <= odd_hist_rt[k-1];
		end
	end

	// Remaining cycles per entry, zero means free
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < hist_depth; k++)
			begin
				even_hist_left[k] <= '0;
				odd_hist_left[k] <= '0;
			end
		end
		else
		begin
			// Stage 1 is one cycle old already
			even_hist_left[0] <= even_valid ? age_one(even_lat) : '0;
			odd_hist_left[0] <= odd_valid ? age_one(odd_lat) : '0;
			for (int k = 1; k < hist_depth; k++)
			begin
				even_hist_left[k] <= age_one(even_hist_left[k-1]);
				odd_hist_left[k] <= age_one(odd_hist_left[k-1]);
			end
		end
	end

	for (genvar k = 0; k < hist_depth; k++)
	begin : g_left_chk
		a_left_bound: assert property (@(posedge clk) disable iff (!rst_n)
			(even_hist_left[k] <= hist_depth) && (odd_hist_left[k] <= hist_depth));
	end

endmodule

// ==== operand_hazard.sv ====
`timescale 1ns/1ps

module operand_hazard import dep_pkg::*;
(
	dep_slot_if.dst pend,
	input logic pend_valid,
	dep_slot_if.dst out_even,
	dep_slot_if.dst out_odd,
	input logic even_valid,
	input logic odd_valid,
	input reg_addr_t even_hist_rt [hist_depth],
	input reg_addr_t odd_hist_rt [hist_depth],
	input lat_t even_hist_left [hist_depth],
	input lat_t odd_hist_left [hist_depth],
	output logic blocked
);

	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rc;
	logic hit;

	assign ra = pend.ra;
	assign rb = pend.rb;
	assign rc = pend.rc;

	// Any source of the pending slot reads r
	function automatic logic reads(reg_addr_t r);
		return (ra == r) || (rb == r) || (rc == r);
	endfunction

	always_comb
	begin
		hit = 1'b0;

		// Slots on the outputs are age 0
		if (even_valid && reads(out_even.rt) &&
			(result_latency(out_even.unit, out_even.opcode) > 4'd1))
			hit = 1'b1;
		if (odd_valid && reads(out_odd.rt) &&
			(result_latency(out_odd.unit, out_odd.opcode) > 4'd1))
			hit = 1'b1;

		// Entry with one cycle left is ready by the next issue
		for (int k = 0; k < hist_depth; k++)
		begin
			if (reads(even_hist_rt[k]) && (even_hist_left[k] > 4'd1))
				hit = 1'b1;
			if (reads(odd_hist_rt[k]) && (odd_hist_left[k] > 4'd1))
				hit = 1'b1;
		end

		blocked = pend_valid && hit;
	end

endmodule

// ==== tb_dep_stage.sv ====
`timescale 1ns/1ps

module tb_dep_stage import dep_pkg::*;
();

	typedef struct
	{
		int gap;
		logic [57:0] ev;
		logic [57:0] od;
		logic fl;
		logic sp;
	} entry_t;

	entry_t pairs [$];
	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic flush = 1'b0;
	logic dec_valid = 1'b0;
	logic exp_split = 1'b0;
	logic [57:0] even_in = '0;
	logic [57:0] odd_in = '0;
	wire dep_ready;
	wire even_valid;
	wire odd_valid;
	wire [57:0] even_out;
	wire [57:0] odd_out;
	int errors;
	int tests_done;
	logic busy;
	int cycles = 0;
	int limit = 1000;

	always #10 clk = ~clk;

	dep_stage i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.dec_valid(dec_valid),
		.dep_ready(dep_ready),
		.even_in_opcode(even_in[57:47]),
		.even_in_unit(even_in[46:44]),
		.even_in_ra(even_in[43:37]),
		.even_in_rb(even_in[36:30]),
		.even_in_rc(even_in[29:23]),
		.even_in_rt(even_in[22:16]),
		.even_in_imm(even_in[15:0]),
		.odd_in_opcode(odd_in[57:47]),
		.odd_in_unit(odd_in[46:44]),
		.odd_in_ra(odd_in[43:37]),
		.odd_in_rb(odd_in[36:30]),
		.odd_in_rc(odd_in[29:23]),
		.odd_in_rt(odd_in[22:16]),
		.odd_in_imm(odd_in[15:0]),
		.even_valid(even_valid),
		.even_opcode(even_out[57:47]),
		.even_unit(even_out[46:44]),
		.even_ra(even_out[43:37]),
		.even_rb(even_out[36:30]),
		.even_rc(even_out[29:23]),
		.even_rt(even_out[22:16]),
		.even_imm(even_out[15:0]),
		.odd_valid(odd_valid),
		.odd_opcode(odd_out[57:47]),
		.odd_unit(odd_out[46:44]),
		.odd_ra(odd_out[43:37]),
		.odd_rb(odd_out[36:30]),
		.odd_rc(odd_out[29:23]),
		.odd_rt(odd_out[22:16]),
		.odd_imm(odd_out[15:0])
	);

	dep_checker i_chk
	(
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.dec_valid(dec_valid),
		.dep_ready(dep_ready),
		.exp_split(exp_split),
		.even_in(even_in),
		.odd_in(odd_in),
		.even_valid(even_valid),
		.odd_valid(odd_valid),
		.even_out(even_out),
		.odd_out(odd_out),
		.errors(errors),
		.tests_done(tests_done),
		.busy(busy)
	);

	function automatic logic [57:0] slot(int op, int unit, int ra, int rb, int rc, int rt,
		int imm);
		return {op[10:0], unit[2:0], ra[6:0], rb[6:0], rc[6:0], rt[6:0], imm[15:0]};
	endfunction

	task automatic add_pair(int gap, logic [57:0] ev, logic [57:0] od, logic fl, logic sp);
		entry_t e;
		e.gap = gap;
		e.ev = ev;
		e.od = od;
		e.fl = fl;
		e.sp = sp;
		pairs.push_back(e);
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped taking or issuing pairs", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		// Independent pairs on sources that nothing writes
		add_pair(2, slot(100, 1, 100, 101, 102, 1, 5), slot(600, 3, 103, 104, 105, 2, -3), 0, 0);
		add_pair(0, slot(101, 2, 106, 107, 108, 3, 7), slot(601, 6, 109, 110, 111, 4, 9), 0, 0);
		add_pair(0, slot(102, 5, 112, 113, 114, 5, 1), slot(602, 7, 115, 116, 117, 6, 2), 0, 0);
		// Cross-pair hazards, one producer class per consumer
		add_pair(3, slot(110, 1, 100, 101, 102, 10, 0), slot(610, 7, 103, 104, 105, 11, 0), 0, 0);
		add_pair(0, slot(111, 1, 10, 101, 102, 12, 0), slot(611, 3, 103, 104, 105, 13, 0), 0, 0);
		add_pair(0, slot(112, 2, 100, 101, 102, 14, 0), slot(612, 6, 13, 104, 105, 15, 0), 0, 0);
		add_pair(0, slot(113, 5, 100, 14, 102, 16, 0), slot(613, 6, 103, 104, 105, 17, 0), 0, 0);
		add_pair(0, slot(114, 5, 100, 101, 102, 18, 0), slot(614, 3, 17, 104, 105, 19, 0), 0, 0);
		add_pair(0, slot(115, 1, 100, 101, 18, 20, 0), slot(615, 6, 103, 104, 105, 21, 0), 0, 0);
		// Float sets, single, long and unlisted
		add_pair(0, slot(707, 4, 100, 101, 102, 22, 0), slot(620, 7, 103, 104, 105, 23, 0), 0, 0);
		add_pair(0, slot(120, 1, 100, 101, 102, 24, 0), slot(621, 3, 22, 104, 105, 25, 0), 0, 0);
		add_pair(0, slot(964, 4, 100, 101, 102, 26, 0), slot(622, 6, 103, 104, 105, 27, 0), 0, 0);
		add_pair(0, slot(121, 1, 26, 101, 102, 28, 0), slot(623, 6, 103, 104, 105, 29, 0), 0, 0);
		add_pair(0, slot(300, 4, 100, 101, 102, 30, 0), slot(624, 7, 103, 104, 105, 31, 0), 0, 0);
		add_pair(0, slot(122, 2, 100, 30, 102, 32, 0), slot(625, 7, 103, 104, 105, 33, 0), 0, 0);
		// Same-pair dependencies
		add_pair(0, slot(130, 1, 100, 101, 102, 40, 0), slot(630, 3, 40, 104, 105, 41, 0), 0, 1);
		add_pair(0, slot(965, 4, 100, 101, 102, 42, 0), slot(631, 6, 103, 42, 105, 43, 0), 0, 1);
		add_pair(0, slot(131, 1, 44, 101, 102, 45, 0), slot(632, 3, 103, 104, 105, 44, 0), 0, 0);
		// Flush of a stalled consumer, then the hazard still holds
		add_pair(8, slot(966, 4, 100, 101, 102, 50, 0), slot(640, 7, 103, 104, 105, 51, 0), 0, 0);
		add_pair(0, slot(140, 1, 50, 101, 102, 52, 0), slot(641, 3, 103, 104, 105, 54, 0), 1, 0);
		add_pair(0, slot(141, 1, 50, 101, 102, 53, 0), slot(642, 6, 103, 104, 105, 55, 0), 0, 0);
		add_pair(0, slot(142, 5, 100, 101, 102, 56, 0), slot(643, 3, 103, 104, 105, 57, 0), 0, 0);

		limit = pairs.size() * (hist_depth + 3) + 10 + 20;
		foreach (pairs[i])
			limit += pairs[i].gap;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		foreach (pairs[i])
		begin
			if (pairs[i].gap > 0)
			begin
				dec_valid <= 1'b0;
				repeat (pairs[i].gap) @(posedge clk);
			end
			even_in <= pairs[i].ev;
			odd_in <= pairs[i].od;
			exp_split <= pairs[i].sp;
			dec_valid <= 1'b1;
			do
				@(negedge clk);
			while (!dep_ready);
			@(posedge clk);
			if (pairs[i].fl)
			begin
				dec_valid <= 1'b0;
				repeat (2) @(posedge clk);
				flush <= 1'b1;
				@(posedge clk);
				flush <= 1'b0;
			end
		end
		dec_valid <= 1'b0;

		do
			@(negedge clk);
		while (busy);
		repeat (hist_depth + 2) @(negedge clk);
		if (tests_done != pairs.size())
			$display("Only %0d of %0d pairs were closed by the checker", tests_done, pairs.size());
		$display("tests %0d of %0d done, errors %0d", tests_done, pairs.size(), errors);
		if (errors == 0 && tests_done == pairs.size())
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
